//--- logic/tk1_map_pkg.sv
package tk1_map_pkg;

  // ----------------------------------------------------------------------
  // Register address map
  // ----------------------------------------------------------------------
  localparam logic [7:0] addr_name0          = 8'h00;
  localparam logic [7:0] addr_name1          = 8'h01;
  localparam logic [7:0] addr_version        = 8'h02;
  localparam logic [7:0] addr_system_mode    = 8'h08;
  localparam logic [7:0] addr_led            = 8'h09;
  localparam logic [7:0] addr_gpio           = 8'h0a;
  localparam logic [7:0] addr_app_start      = 8'h0c;
  localparam logic [7:0] addr_app_size       = 8'h0d;
  localparam logic [7:0] addr_blake2s        = 8'h10;
  localparam logic [7:0] addr_syscall        = 8'h12;
  localparam logic [7:0] addr_cdi_first      = 8'h20;
  localparam logic [7:0] addr_cdi_last       = 8'h27;
  localparam logic [7:0] addr_cpu_mon_ctrl   = 8'h60;
  localparam logic [7:0] addr_cpu_mon_first  = 8'h61;
  localparam logic [7:0] addr_cpu_mon_last   = 8'h62;
  localparam logic [7:0] addr_system_reset   = 8'h70;

  // Identification, ASCII "tk1 " and "mkdf"
  localparam logic [31:0] tk1_name0   = 32'h746b3120;
  localparam logic [31:0] tk1_name1   = 32'h6d6b6466;
  localparam logic [31:0] tk1_version = 32'h00000005;

  // Colour positions in the LED field
  localparam int led_bit_r = 2;
  localparam int led_bit_g = 1;
  localparam int led_bit_b = 0;

  // Lies outside physical memory, so a fetch there traps
  localparam logic [31:0] illegal_addr = 32'h4f000000;

  // ----------------------------------------------------------------------
  // APB signals
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
  } apb_rsp_t;

endpackage

//--- logic/tk1_mem_pkg.sv
package tk1_mem_pkg;

  // ----------------------------------------------------------------------
  // CPU memory map
  // ----------------------------------------------------------------------
  localparam logic [31:0] fw_ram_first = 32'hd0000000;
  localparam logic [31:0] fw_ram_last  = 32'hd00007ff;
  // ROM starts at address zero
  localparam logic [31:0] fw_rom_last  = 32'h00001fff;

  // Flat address, or region plus offset split for the RAM size check
  typedef union packed {
    logic [31:0] flat;
    struct packed {
      logic [1:0]  region;
      logic [12:0] ram_high;
      logic [16:0] ram_low;
    } ram;
  } cpu_addr_u;

  typedef struct packed {
    logic      valid;
    logic      instr;
    cpu_addr_u addr;
  } cpu_access_t;

  // ----------------------------------------------------------------------
  // Security configuration and state
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [31:0] syscall_addr;
    logic [31:0] blake2s_addr;
    logic        mon_en;
    logic [31:0] mon_first;
    logic [31:0] mon_last;
  } sec_cfg_t;

  typedef struct packed {
    logic system_mode;
    logic rw_locked;
  } sec_state_t;

endpackage

//--- logic/tk1_apb_regs.sv
module tk1_apb_regs (
  input  logic                    clk,
  input  logic                    reset_n,
  input  tk1_map_pkg::apb_req_t   apb_req,
  output tk1_map_pkg::apb_rsp_t   apb_rsp,
  input  tk1_mem_pkg::sec_state_t sec_state,
  output tk1_mem_pkg::sec_cfg_t   sec_cfg,
  output logic [2:0]              led_sw,
  input  logic                    gpio1,
  input  logic                    gpio2,
  output logic                    gpio3,
  output logic                    gpio4,
  output logic                    system_reset
);

  localparam int gpio1_bit = 0;
  localparam int gpio2_bit = 1;
  localparam int gpio3_bit = 2;
  localparam int gpio4_bit = 3;

  // Red and green on out of reset
  localparam logic [2:0] led_init =
    (3'b001 << tk1_map_pkg::led_bit_r) | (3'b001 << tk1_map_pkg::led_bit_g);

  logic [31:0] cdi_mem [8];
  logic [31:0] app_start_reg;
  logic [31:0] app_size_reg;
  logic [31:0] blake2s_addr_reg;
  logic [31:0] syscall_addr_reg;
  logic        mon_en_reg;
  logic [31:0] mon_first_reg;
  logic [31:0] mon_last_reg;
  logic [2:0]  led_reg;
  logic [1:0]  gpio1_sync;
  logic [1:0]  gpio2_sync;
  logic        gpio3_reg;
  logic        gpio4_reg;
  logic        system_reset_reg;

  logic        access;
  logic        wr_en;
  logic        locked;
  logic        cdi_hit;
  logic        cdi_we;
  logic [31:0] rdata;
  logic [31:0] gpio_word;

  // ----------------------------------------------------------------------
  // Access decode
  // ----------------------------------------------------------------------
  assign access  = apb_req.psel && apb_req.penable;
  assign wr_en   = access && apb_req.pwrite;
  assign locked  = sec_state.rw_locked;
  assign cdi_hit = (apb_req.paddr >= tk1_map_pkg::addr_cdi_first) &&
                   (apb_req.paddr <= tk1_map_pkg::addr_cdi_last);
  assign cdi_we  = wr_en && cdi_hit && !locked;

  // ----------------------------------------------------------------------
  // Register storage
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      app_start_reg    <= '0;
      app_size_reg     <= '0;
      blake2s_addr_reg <= tk1_map_pkg::illegal_addr;
      syscall_addr_reg <= tk1_map_pkg::illegal_addr;
      mon_en_reg       <= 1'b0;
      mon_first_reg    <= '0;
      mon_last_reg     <= '0;
      led_reg          <= led_init;
      gpio1_sync       <= '0;
      gpio2_sync       <= '0;
      gpio3_reg        <= 1'b0;
      gpio4_reg        <= 1'b0;
      system_reset_reg <= 1'b0;
    end else begin
      gpio1_sync       <= {gpio1_sync[0], gpio1};
      gpio2_sync       <= {gpio2_sync[0], gpio2};
      system_reset_reg <= wr_en && (apb_req.paddr == tk1_map_pkg::addr_system_reset);

      if (wr_en) begin
        case (apb_req.paddr)
          tk1_map_pkg::addr_led: led_reg <= apb_req.pwdata[2:0];
          tk1_map_pkg::addr_gpio: begin
            gpio3_reg <= apb_req.pwdata[gpio3_bit];
            gpio4_reg <= apb_req.pwdata[gpio4_bit];
          end
          tk1_map_pkg::addr_app_start: if (!locked) app_start_reg <= apb_req.pwdata;
          tk1_map_pkg::addr_app_size: if (!locked) app_size_reg <= apb_req.pwdata;
          tk1_map_pkg::addr_blake2s: if (!locked) blake2s_addr_reg <= apb_req.pwdata;
          tk1_map_pkg::addr_syscall: if (!locked) syscall_addr_reg <= apb_req.pwdata;
          // Enable is one-way, data is don't care
          tk1_map_pkg::addr_cpu_mon_ctrl: mon_en_reg <= 1'b1;
          tk1_map_pkg::addr_cpu_mon_first: if (!mon_en_reg) mon_first_reg <= apb_req.pwdata;
          tk1_map_pkg::addr_cpu_mon_last: if (!mon_en_reg) mon_last_reg <= apb_req.pwdata;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cdi_we) begin
      cdi_mem[apb_req.paddr[2:0]] <= apb_req.pwdata;
    end
  end

  // ----------------------------------------------------------------------
  // Read mux
  // ----------------------------------------------------------------------
  always_comb begin
    gpio_word            = '0;
    gpio_word[gpio1_bit] = gpio1_sync[1];
    gpio_word[gpio2_bit] = gpio2_sync[1];
    gpio_word[gpio3_bit] = gpio3_reg;
    gpio_word[gpio4_bit] = gpio4_reg;
  end

  always_comb begin
    rdata = '0;
    if (access && !apb_req.pwrite) begin
      case (apb_req.paddr)
        tk1_map_pkg::addr_name0:         rdata = tk1_map_pkg::tk1_name0;
        tk1_map_pkg::addr_name1:         rdata = tk1_map_pkg::tk1_name1;
        tk1_map_pkg::addr_version:       rdata = tk1_map_pkg::tk1_version;
        tk1_map_pkg::addr_system_mode:   rdata = {32{sec_state.system_mode}};
        tk1_map_pkg::addr_led:           rdata = {29'b0, led_reg};
        tk1_map_pkg::addr_gpio:          rdata = gpio_word;
        tk1_map_pkg::addr_app_start:     rdata = app_start_reg;
        tk1_map_pkg::addr_app_size:      rdata = app_size_reg;
        tk1_map_pkg::addr_blake2s:       rdata = blake2s_addr_reg;
        tk1_map_pkg::addr_syscall:       rdata = syscall_addr_reg;
        tk1_map_pkg::addr_cpu_mon_ctrl:  rdata = {31'b0, mon_en_reg};
        tk1_map_pkg::addr_cpu_mon_first: rdata = mon_first_reg;
        tk1_map_pkg::addr_cpu_mon_last:  rdata = mon_last_reg;
        default: begin
          if (cdi_hit) begin
            rdata = cdi_mem[apb_req.paddr[2:0]];
          end
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------------------
  assign apb_rsp = '{prdata: rdata, pready: access};

  assign sec_cfg = '{
    syscall_addr: syscall_addr_reg,
    blake2s_addr: blake2s_addr_reg,
    mon_en:       mon_en_reg,
    mon_first:    mon_first_reg,
    mon_last:     mon_last_reg
  };

  assign led_sw       = led_reg;
  assign gpio3        = gpio3_reg;
  assign gpio4        = gpio4_reg;
  assign system_reset = system_reset_reg;

  // Ready only in an access phase, which always follows a setup phase
  a_pready_access: assert property (@(posedge clk) disable iff (!reset_n)
    apb_rsp.pready |-> $past(apb_req.psel && !apb_req.penable));

  // Setup phase between accesses keeps the reset request to one cycle
  a_reset_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    system_reset |=> !system_reset);

endmodule

//--- logic/tk1_security_monitor.sv
module tk1_security_monitor (
  input  logic                     clk,
  input  logic                     reset_n,
  input  tk1_mem_pkg::cpu_access_t cpu_access,
  input  tk1_mem_pkg::sec_cfg_t    sec_cfg,
  output tk1_mem_pkg::sec_state_t  sec_state,
  output logic                     force_trap
);

  logic        system_mode_reg;
  logic        rom_exec_reg;
  logic        rw_locked_reg;
  logic        force_trap_reg;

  logic        fetch;
  logic [31:0] addr;
  logic        trap_set;
  logic        mode_we;
  logic        mode_new;
  logic        rom_we;
  logic        rom_new;

  assign fetch = cpu_access.valid && cpu_access.instr;
  assign addr  = cpu_access.addr.flat;

  // ----------------------------------------------------------------------
  // Rule checks
  // ----------------------------------------------------------------------
  always_comb begin
    trap_set = 1'b0;
    // RAM region beyond the physical size
    if (cpu_access.valid && (cpu_access.addr.ram.region == 2'd1) &&
        (|cpu_access.addr.ram.ram_high)) begin
      trap_set = 1'b1;
    end
    if (fetch) begin
      if ((addr >= tk1_mem_pkg::fw_ram_first) && (addr <= tk1_mem_pkg::fw_ram_last)) begin
        trap_set = 1'b1;
      end
      // Entry addresses are let through even with ROM closed
      if (!rom_exec_reg && (addr <= tk1_mem_pkg::fw_rom_last) &&
          (addr != sec_cfg.syscall_addr) && (addr != sec_cfg.blake2s_addr)) begin
        trap_set = 1'b1;
      end
      if (sec_cfg.mon_en && (addr >= sec_cfg.mon_first) && (addr <= sec_cfg.mon_last)) begin
        trap_set = 1'b1;
      end
    end
  end

  // Later checks take priority
  always_comb begin
    mode_we  = 1'b0;
    mode_new = 1'b0;
    rom_we   = 1'b0;
    rom_new  = 1'b0;
    if (fetch) begin
      if (addr == sec_cfg.syscall_addr) begin
        mode_we = 1'b1;
        rom_we  = 1'b1;
        rom_new = 1'b1;
      end
      if (addr == sec_cfg.blake2s_addr) begin
        rom_we  = 1'b1;
        rom_new = 1'b1;
      end
      // Leaving ROM drops privilege
      if (addr > tk1_mem_pkg::fw_rom_last) begin
        mode_we  = 1'b1;
        mode_new = 1'b1;
        rom_we   = 1'b1;
        rom_new  = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      system_mode_reg <= 1'b0;
      rom_exec_reg    <= 1'b1;
      rw_locked_reg   <= 1'b0;
      force_trap_reg  <= 1'b0;
    end else begin
      if (mode_we) begin
        system_mode_reg <= mode_new;
        if (mode_new) begin
          rw_locked_reg <= 1'b1;
        end
      end
      if (rom_we) begin
        rom_exec_reg <= rom_new;
      end
      if (trap_set) begin
        force_trap_reg <= 1'b1;
      end
    end
  end

  assign sec_state  = '{system_mode: system_mode_reg, rw_locked: rw_locked_reg};
  assign force_trap = force_trap_reg;

  // Entry addresses stay fixed once the register lock is set
  a_entry_locked: assert property (@(posedge clk) disable iff (!reset_n)
    sec_state.rw_locked |=>
      ($stable(sec_cfg.syscall_addr) && $stable(sec_cfg.blake2s_addr)));

endmodule

//--- logic/tk1_status_led.sv
module tk1_status_led #(
  parameter int blink_ctr_width = 24
) (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       cpu_trap,
  input  logic [2:0] led_sw,
  output logic       led_r,
  output logic       led_g,
  output logic       led_b
);

  logic [blink_ctr_width-1:0] blink_ctr;
  logic                       trap_red;
  logic [2:0]                 trap_led;
  logic [2:0]                 led_src;

  // Free-running, red flips on every wrap
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      blink_ctr <= '0;
      trap_red  <= 1'b0;
    end else begin
      blink_ctr <= blink_ctr + 1'b1;
      if (blink_ctr == '0) begin
        trap_red <= ~trap_red;
      end
    end
  end

  always_comb begin
    trap_led                         = '0;
    trap_led[tk1_map_pkg::led_bit_r] = trap_red;
  end

  // Trap pattern overrides the software setting
  assign led_src = cpu_trap ? trap_led : led_sw;

  assign led_r = led_src[tk1_map_pkg::led_bit_r];
  assign led_g = led_src[tk1_map_pkg::led_bit_g];
  assign led_b = led_src[tk1_map_pkg::led_bit_b];

endmodule

//--- logic/tk1_core.sv
module tk1_core #(
  parameter int blink_ctr_width = 24
) (
  input  logic                     clk,
  input  logic                     reset_n,
  input  tk1_map_pkg::apb_req_t    apb_req,
  output tk1_map_pkg::apb_rsp_t    apb_rsp,
  input  tk1_mem_pkg::cpu_access_t cpu_access,
  input  logic                     cpu_trap,
  output logic                     force_trap,
  output logic                     system_mode,
  output logic                     system_reset,
  output logic                     led_r,
  output logic                     led_g,
  output logic                     led_b,
  input  logic                     gpio1,
  input  logic                     gpio2,
  output logic                     gpio3,
  output logic                     gpio4
);

  tk1_mem_pkg::sec_cfg_t   sec_cfg;
  tk1_mem_pkg::sec_state_t sec_state;
  logic [2:0]              led_sw;

  tk1_apb_regs u_regs (
    .clk          (clk),
    .reset_n      (reset_n),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .sec_state    (sec_state),
    .sec_cfg      (sec_cfg),
    .led_sw       (led_sw),
    .gpio1        (gpio1),
    .gpio2        (gpio2),
    .gpio3        (gpio3),
    .gpio4        (gpio4),
    .system_reset (system_reset)
  );

  tk1_security_monitor u_monitor (
    .clk        (clk),
    .reset_n    (reset_n),
    .cpu_access (cpu_access),
    .sec_cfg    (sec_cfg),
    .sec_state  (sec_state),
    .force_trap (force_trap)
  );

  tk1_status_led #(
    .blink_ctr_width (blink_ctr_width)
  ) u_led (
    .clk      (clk),
    .reset_n  (reset_n),
    .cpu_trap (cpu_trap),
    .led_sw   (led_sw),
    .led_r    (led_r),
    .led_g    (led_g),
    .led_b    (led_b)
  );

  assign system_mode = sec_state.system_mode;

endmodule

//--- dv/tk1_tests.svh
`ifndef TK1_TESTS_SVH
`define TK1_TESTS_SVH

localparam logic [31:0] syscall_entry = 32'h0000_0100;
localparam logic [31:0] blake2s_entry = 32'h0000_0200;
localparam logic [31:0] rom_plain     = 32'h0000_0400;
localparam logic [31:0] above_rom     = 32'h4000_0000;
localparam logic [31:0] mon_lo        = 32'h4000_8000;
localparam logic [31:0] mon_hi        = 32'h4000_8fff;

function automatic logic [31:0] cdi_pattern(input int idx);
  return {8'h5a, 8'(idx), 8'hc3, 8'(~idx)};
endfunction

task automatic check_led_pins(input logic [2:0] value);
  @(negedge clk);
  check_value(32'(led_r), 32'(value[tk1_map_pkg::led_bit_r]), "led_r pin");
  check_value(32'(led_g), 32'(value[tk1_map_pkg::led_bit_g]), "led_g pin");
  check_value(32'(led_b), 32'(value[tk1_map_pkg::led_bit_b]), "led_b pin");
endtask

// Cycles until led_r changes, with green and blue held low meanwhile
task automatic count_red_gap(output int cycles);
  logic prev_red;
  prev_red = led_r;
  cycles   = 0;
  do begin
    @(negedge clk);
    cycles++;
    check_value(32'(led_g), 32'h0, "led_g low while trapped");
    check_value(32'(led_b), 32'h0, "led_b low while trapped");
  end while (led_r == prev_red && cycles <= blink_period);
endtask

// ----------------------------------------------------------------------
// Directed tests
// ----------------------------------------------------------------------
task automatic test_ident_reset();
  logic [31:0] rd;
  apb_read(tk1_map_pkg::addr_name0, rd);
  check_value(rd, tk1_map_pkg::tk1_name0, "name0");
  apb_read(tk1_map_pkg::addr_name1, rd);
  check_value(rd, tk1_map_pkg::tk1_name1, "name1");
  apb_read(tk1_map_pkg::addr_version, rd);
  check_value(rd, tk1_map_pkg::tk1_version, "version");
  apb_read(tk1_map_pkg::addr_led, rd);
  check_value(rd, led_reset, "led reset value");
  apb_read(tk1_map_pkg::addr_system_mode, rd);
  check_value(rd, 32'h0, "system_mode reset value");
  @(negedge clk);
  check_value(32'(force_trap), 32'h0, "force_trap after reset");
  check_value(32'(system_reset), 32'h0, "system_reset after reset");
  check_value(32'(system_mode), 32'h0, "system_mode pin after reset");
  check_value(32'({gpio4, gpio3}), 32'h0, "gpio outputs after reset");
endtask

task automatic test_regs_gpio();
  logic [31:0] rd;
  int          high_cycles;
  apb_write(tk1_map_pkg::addr_app_start, 32'h0001_0000);
  apb_read(tk1_map_pkg::addr_app_start, rd);
  check_value(rd, 32'h0001_0000, "app_start readback");
  apb_write(tk1_map_pkg::addr_app_size, 32'h0000_4000);
  apb_read(tk1_map_pkg::addr_app_size, rd);
  check_value(rd, 32'h0000_4000, "app_size readback");
  for (int i = 0; i < 8; i++) begin
    apb_write(8'(tk1_map_pkg::addr_cdi_first + i), cdi_pattern(i));
  end
  for (int i = 0; i < 8; i++) begin
    apb_read(8'(tk1_map_pkg::addr_cdi_first + i), rd);
    check_value(rd, cdi_pattern(i), "cdi readback");
  end
  apb_write(tk1_map_pkg::addr_led, 32'h5);
  apb_read(tk1_map_pkg::addr_led, rd);
  check_value(rd, 32'h5, "led readback");
  check_led_pins(3'b101);

  // Inputs pass a two-stage synchronizer
  @(posedge clk);
  gpio1 <= 1'b1;
  gpio2 <= 1'b0;
  repeat (3) @(posedge clk);
  apb_read(tk1_map_pkg::addr_gpio, rd);
  check_value(32'(rd[1:0]), 32'h1, "gpio inputs 1 and 0");
  @(posedge clk);
  gpio1 <= 1'b0;
  gpio2 <= 1'b1;
  repeat (3) @(posedge clk);
  apb_read(tk1_map_pkg::addr_gpio, rd);
  check_value(32'(rd[1:0]), 32'h2, "gpio inputs 0 and 1");
  apb_write(tk1_map_pkg::addr_gpio, 32'h0000_000c);
  @(negedge clk);
  check_value(32'({gpio4, gpio3}), 32'h3, "gpio3 and gpio4 set");
  apb_write(tk1_map_pkg::addr_gpio, 32'h0000_0004);
  @(negedge clk);
  check_value(32'({gpio4, gpio3}), 32'h1, "gpio3 set, gpio4 clear");

  // Reset request is high in the cycle after the access phase only
  apb_write(tk1_map_pkg::addr_system_reset, 32'h1);
  @(negedge clk);
  check_value(32'(system_reset), 32'h1, "system_reset after write");
  high_cycles = 1;
  repeat (5) begin
    @(negedge clk);
    if (system_reset) high_cycles++;
  end
  check_value(32'(high_cycles), 32'h1, "system_reset high cycles");
endtask

task automatic test_lock();
  logic [31:0] rd;
  logic [31:0] app_before;
  apb_read(tk1_map_pkg::addr_app_start, app_before);
  cpu_op(above_rom, 1'b1);
  @(negedge clk);
  check_value(32'(system_mode), 32'h1, "system_mode pin after leaving ROM");
  check_value(32'(force_trap), 32'h0, "no trap on fetch above ROM");
  apb_read(tk1_map_pkg::addr_system_mode, rd);
  check_value(rd, 32'hffff_ffff, "system_mode read in system mode");
  apb_write(tk1_map_pkg::addr_app_start, ~app_before);
  apb_read(tk1_map_pkg::addr_app_start, rd);
  check_value(rd, app_before, "app_start locked");
  // CDI still holds the words of the register test
  for (int i = 0; i < 8; i++) begin
    apb_write(8'(tk1_map_pkg::addr_cdi_first + i), 32'hffff_0000);
  end
  for (int i = 0; i < 8; i++) begin
    apb_read(8'(tk1_map_pkg::addr_cdi_first + i), rd);
    check_value(rd, cdi_pattern(i), "cdi locked");
  end
  apb_write(tk1_map_pkg::addr_led, 32'h3);
  apb_read(tk1_map_pkg::addr_led, rd);
  check_value(rd, 32'h3, "led writable when locked");
  check_led_pins(3'b011);
endtask

task automatic test_syscall_rom();
  logic [31:0] rd;
  apply_reset();
  apb_write(tk1_map_pkg::addr_syscall, syscall_entry);
  apb_write(tk1_map_pkg::addr_blake2s, blake2s_entry);
  cpu_op(above_rom, 1'b1);
  apb_read(tk1_map_pkg::addr_system_mode, rd);
  check_value(rd, 32'hffff_ffff, "system mode before syscall");
  cpu_op(syscall_entry, 1'b1);
  check_trap(1'b0, "no trap at syscall entry");
  apb_read(tk1_map_pkg::addr_system_mode, rd);
  check_value(rd, 32'h0, "syscall clears system mode");
  cpu_op(rom_plain, 1'b1);
  check_trap(1'b0, "ROM fetch after syscall");
  cpu_op(above_rom, 1'b1);
  cpu_op(blake2s_entry, 1'b1);
  check_trap(1'b0, "no trap at blake2s entry");
  check_value(32'(system_mode), 32'h1, "blake2s keeps system mode");
  cpu_op(rom_plain, 1'b1);
  check_trap(1'b0, "ROM fetch after blake2s");
  cpu_op(above_rom, 1'b1);
  cpu_op(rom_plain, 1'b1);
  check_trap(1'b1, "ROM fetch with ROM closed");
endtask

task automatic test_mem_traps();
  logic [31:0] rd;
  apply_reset();
  cpu_op(tk1_mem_pkg::fw_ram_first + 32'h10, 1'b1);
  check_trap(1'b1, "fetch from firmware RAM");

  // Region 1 is bits 31:30, ram_high bits 29:17
  apply_reset();
  cpu_op(32'h4000_1000, 1'b0);
  check_trap(1'b0, "region 1 access inside RAM size");
  cpu_op(32'h4002_0000, 1'b0);
  check_trap(1'b1, "region 1 access beyond RAM size");

  apply_reset();
  apb_write(tk1_map_pkg::addr_cpu_mon_first, mon_lo);
  apb_write(tk1_map_pkg::addr_cpu_mon_last, mon_hi);
  apb_write(tk1_map_pkg::addr_cpu_mon_ctrl, 32'h0);
  apb_write(tk1_map_pkg::addr_cpu_mon_first, 32'h0);
  apb_write(tk1_map_pkg::addr_cpu_mon_last, 32'hffff_ffff);
  apb_read(tk1_map_pkg::addr_cpu_mon_first, rd);
  check_value(rd, mon_lo, "monitor first frozen");
  apb_read(tk1_map_pkg::addr_cpu_mon_last, rd);
  check_value(rd, mon_hi, "monitor last frozen");
  cpu_op(mon_lo + 32'h100, 1'b0);
  check_trap(1'b0, "data access in monitor range");
  cpu_op(mon_hi + 32'h100, 1'b1);
  check_trap(1'b0, "fetch above monitor range");
  cpu_op(mon_lo + 32'h100, 1'b1);
  check_trap(1'b1, "fetch in monitor range");
endtask

task automatic test_trap_blink();
  logic [31:0] rd;
  int          gap;
  apb_write(tk1_map_pkg::addr_led, 32'h1);
  @(posedge clk);
  cpu_trap <= 1'b1;
  @(negedge clk);
  // First gap starts at an arbitrary counter value
  count_red_gap(gap);
  check_value(32'(gap <= blink_period), 32'h1, "led_r toggles while trapped");
  repeat (2) begin
    count_red_gap(gap);
    check_value(32'(gap), 32'(blink_period), "cycles between led_r toggles");
  end
  @(posedge clk);
  cpu_trap <= 1'b0;
  apb_read(tk1_map_pkg::addr_led, rd);
  check_value(rd, 32'h1, "led register kept during trap");
  check_led_pins(3'b001);
  // Trap from the monitor range test is still held
  check_value(32'(force_trap), 32'h1, "force_trap held until reset");
endtask

`endif

//--- dv/tk1_tb.sv
module tk1_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int blink_w      = 4;
  localparam int blink_period = 1 << blink_w;
  localparam int clk_period   = 8;
  localparam int reset_cycles = 16;

  // Red and green on out of reset
  localparam logic [31:0] led_reset =
    (32'd1 << tk1_map_pkg::led_bit_r) | (32'd1 << tk1_map_pkg::led_bit_g);

  // Cycle budget per test, reset sequences included
  localparam int budget_ident = 60;
  localparam int budget_regs  = 200;
  localparam int budget_lock  = 120;
  localparam int budget_rom   = 120;
  localparam int budget_mem   = 200;
  localparam int budget_blink = 150;
  localparam int total_cycles = budget_ident + budget_regs + budget_lock +
                                budget_rom + budget_mem + budget_blink;
  // Four times the estimate
  localparam int watchdog_ns  = 4 * total_cycles * clk_period;

  logic                     clk;
  logic                     reset_n;
  tk1_map_pkg::apb_req_t    apb_req;
  tk1_map_pkg::apb_rsp_t    apb_rsp;
  tk1_mem_pkg::cpu_access_t cpu_access;
  logic                     cpu_trap;
  logic                     force_trap;
  logic                     system_mode;
  logic                     system_reset;
  logic                     led_r;
  logic                     led_g;
  logic                     led_b;
  logic                     gpio1;
  logic                     gpio2;
  logic                     gpio3;
  logic                     gpio4;
  int                       error_count;

  tk1_core #(
    .blink_ctr_width (blink_w)
  ) UUT (
    .clk          (clk),
    .reset_n      (reset_n),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .cpu_access   (cpu_access),
    .cpu_trap     (cpu_trap),
    .force_trap   (force_trap),
    .system_mode  (system_mode),
    .system_reset (system_reset),
    .led_r        (led_r),
    .led_g        (led_g),
    .led_b        (led_b),
    .gpio1        (gpio1),
    .gpio2        (gpio2),
    .gpio3        (gpio3),
    .gpio4        (gpio4)
  );

  always #(clk_period / 2) clk = ~clk;

  // --------------------------------------------------------------------
  // Driver and check tasks
  // --------------------------------------------------------------------
  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      error_count++;
      $display("Fail at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Testbench failed");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset_n    <= 1'b0;
    apb_req    <= '0;
    cpu_access <= '0;
    cpu_trap   <= 1'b0;
    repeat (reset_cycles) @(posedge clk);
    reset_n <= 1'b1;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(negedge clk);
    check_value(32'(apb_rsp.pready), 32'h0, "pready in write setup phase");
    @(posedge clk);
    apb_req.penable <= 1'b1;
    // No wait states, so the access phase is a single cycle
    @(negedge clk);
    check_value(32'(apb_rsp.pready), 32'h1, "pready in write access phase");
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
    @(negedge clk);
    check_value(32'(apb_rsp.pready), 32'h0, "pready in read setup phase");
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    check_value(32'(apb_rsp.pready), 32'h1, "pready in read access phase");
    data = apb_rsp.prdata;
    @(posedge clk);
    apb_req <= '0;
  endtask

  // One-cycle CPU access, seen by the monitor at the edge that ends it
  task automatic cpu_op(input logic [31:0] addr, input logic instr);
    tk1_mem_pkg::cpu_access_t acc;
    acc.valid     = 1'b1;
    acc.instr     = instr;
    acc.addr.flat = addr;
    @(posedge clk);
    cpu_access <= acc;
    @(posedge clk);
    cpu_access <= '0;
  endtask

  task automatic check_trap(input logic expected, input string what);
    @(negedge clk);
    check_value(32'(force_trap), 32'(expected), what);
  endtask

  `include "tk1_tests.svh"

  // --------------------------------------------------------------------
  // Test sequence and watchdog
  // --------------------------------------------------------------------
  initial begin
    clk         = 1'b0;
    reset_n     = 1'b0;
    apb_req     = '0;
    cpu_access  = '0;
    cpu_trap    = 1'b0;
    gpio1       = 1'b0;
    gpio2       = 1'b0;
    error_count = 0;
    apply_reset();
    test_ident_reset();
    test_regs_gpio();
    test_lock();
    test_syscall_rom();
    test_mem_traps();
    test_trap_blink();
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("Timeout: the tests were still running after %0d ns", watchdog_ns);
    $display("Testbench failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

//--- vlog.f
+incdir+dv
logic/tk1_map_pkg.sv
logic/tk1_mem_pkg.sv
logic/tk1_apb_regs.sv
logic/tk1_security_monitor.sv
logic/tk1_status_led.sv
logic/tk1_core.sv
dv/tk1_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		-f vlog.f --top-module tk1_tb -Mdir obj_dir -o tk1_sim

run: compile
	./obj_dir/tk1_sim | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
